/* rv_core_pkg.sv */
package rv_core_pkg;

	// ********************************************************
	// Memory map and sizes
	// ********************************************************

	localparam logic [31:0] RESET_PC = 32'h0000_0000;

	localparam int IMEM_DEPTH = 64; // Instruction words
	localparam int DMEM_DEPTH = 64; // Data words
	localparam int IMEM_AW    = $clog2(IMEM_DEPTH);

	// ********************************************************
	// Major opcodes, instr[6:0]
	// ********************************************************

	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;

	// ********************************************************
	// Control encodings
	// ********************************************************

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_SLL,
		ALU_SLT,
		ALU_SLTU,
		ALU_XOR,
		ALU_SRL,
		ALU_SRA,
		ALU_OR,
		ALU_AND,
		ALU_PASS_B // Used by LUI
	} alu_op_e;

	typedef enum logic [2:0] {
		BR_NONE,
		BR_EQ,
		BR_NE,
		BR_LT,
		BR_GE,
		BR_LTU,
		BR_GEU
	} br_op_e;

	// Same order as funct3[1:0] of loads and stores
	typedef enum logic [1:0] {
		MEM_BYTE,
		MEM_HALF,
		MEM_WORD
	} mem_size_e;

	typedef enum logic [1:0] {
		WB_ALU,
		WB_MEM,
		WB_LINK // pc + 4 for JAL and JALR
	} wb_sel_e;

endpackage

/* rv_fetch.sv */
`timescale 1ns/1ps

module rv_fetch (
	input  logic        clk,
	input  logic        rst_i,
	input  logic        jump_en_i,
	input  logic [31:0] jump_addr_i,
	output logic [31:0] pc_o
);

	logic [31:0] pc;
	logic [31:0] pc_next;

	// Taken branches and jumps override the sequential address
	always_comb begin
		if (jump_en_i) begin
			pc_next = jump_addr_i;
		end else begin
			pc_next = pc + 32'd4;
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			pc <= rv_core_pkg::RESET_PC;
		end else begin
			pc <= pc_next;
		end
	end

	assign pc_o = pc;

endmodule

/* rv_imem.sv */
`timescale 1ns/1ps

module rv_imem (
	input  logic                           clk,
	input  logic                           rst_i,
	input  logic                           we_i,
	input  logic [rv_core_pkg::IMEM_AW-1:0] waddr_i,
	input  logic [31:0]                    wdata_i,
	input  logic [31:0]                    pc_i,
	output logic [31:0]                    instr_o
);

	logic [31:0] mem [rv_core_pkg::IMEM_DEPTH];

	logic [rv_core_pkg::IMEM_AW-1:0] raddr;

	// Program load happens only while the core is held in reset
	always_ff @(posedge clk) begin
		if (rst_i && we_i) begin
			mem[waddr_i] <= wdata_i;
		end
	end

	assign raddr   = pc_i[rv_core_pkg::IMEM_AW+1:2]; // Upper PC bits wrap
	assign instr_o = mem[raddr];

endmodule

/* rv_decode.sv */
`timescale 1ns/1ps

module rv_decode (
	input  logic [31:0]            pc_i,
	input  logic [31:0]            instr_i,
	input  logic [31:0]            rs1_data_i,
	input  logic [31:0]            rs2_data_i,
	output logic [4:0]             rs1_addr_o,
	output logic [4:0]             rs2_addr_o,
	output rv_core_pkg::alu_op_e   alu_op_o,
	output rv_core_pkg::br_op_e    br_op_o,
	output logic                   is_jal_o,
	output logic                   is_jalr_o,
	output logic [31:0]            op_a_o,
	output logic [31:0]            op_b_o,
	output logic [31:0]            imm_o,
	output logic [31:0]            rs1_data_o,
	output logic [31:0]            rs2_data_o,
	output logic [4:0]             rd_addr_o,
	output logic                   reg_we_o,
	output logic                   mem_we_o,
	output logic                   mem_re_o,
	output rv_core_pkg::mem_size_e mem_size_o,
	output logic                   load_unsigned_o,
	output rv_core_pkg::wb_sel_e   wb_sel_o
);

	logic [6:0]  opcode;
	logic [2:0]  funct3;
	logic [6:0]  funct7;
	logic [31:0] imm_i_type;
	logic [31:0] imm_s_type;
	logic [31:0] imm_b_type;
	logic [31:0] imm_u_type;
	logic [31:0] imm_j_type;

	rv_core_pkg::alu_op_e alu_f;
	rv_core_pkg::br_op_e  br_f;

	assign opcode = instr_i[6:0];
	assign funct3 = instr_i[14:12];
	assign funct7 = instr_i[31:25];

	assign rs1_addr_o = instr_i[19:15];
	assign rs2_addr_o = instr_i[24:20];
	assign rd_addr_o  = instr_i[11:7];

	// ********************************************************
	// Immediates
	// ********************************************************

	assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
	assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
	assign imm_b_type = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
	assign imm_u_type = {instr_i[31:12], 12'b0};
	assign imm_j_type = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

	// ********************************************************
	// funct3 / funct7 decoding
	// ********************************************************

	always_comb begin
		case (funct3)
			3'b000:  alu_f = (opcode == rv_core_pkg::OPC_OP && funct7[5]) ?
				rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
			3'b001:  alu_f = rv_core_pkg::ALU_SLL;
			3'b010:  alu_f = rv_core_pkg::ALU_SLT;
			3'b011:  alu_f = rv_core_pkg::ALU_SLTU;
			3'b100:  alu_f = rv_core_pkg::ALU_XOR;
			3'b101:  alu_f = funct7[5] ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
			3'b110:  alu_f = rv_core_pkg::ALU_OR;
			default: alu_f = rv_core_pkg::ALU_AND;
		endcase
	end

	always_comb begin
		case (funct3)
			3'b000:  br_f = rv_core_pkg::BR_EQ;
			3'b001:  br_f = rv_core_pkg::BR_NE;
			3'b100:  br_f = rv_core_pkg::BR_LT;
			3'b101:  br_f = rv_core_pkg::BR_GE;
			3'b110:  br_f = rv_core_pkg::BR_LTU;
			3'b111:  br_f = rv_core_pkg::BR_GEU;
			default: br_f = rv_core_pkg::BR_NONE;
		endcase
	end

	always_comb begin
		case (funct3[1:0])
			2'b00:   mem_size_o = rv_core_pkg::MEM_BYTE;
			2'b01:   mem_size_o = rv_core_pkg::MEM_HALF;
			default: mem_size_o = rv_core_pkg::MEM_WORD;
		endcase
	end

	assign load_unsigned_o = funct3[2]; // LBU and LHU
	assign rs1_data_o      = rs1_data_i;
	assign rs2_data_o      = rs2_data_i;

	// ********************************************************
	// Per-opcode control
	// ********************************************************

	always_comb begin
		// Defaults leave an unknown opcode with every enable cleared
		alu_op_o  = rv_core_pkg::ALU_ADD;
		br_op_o   = rv_core_pkg::BR_NONE;
		is_jal_o  = 1'b0;
		is_jalr_o = 1'b0;
		reg_we_o  = 1'b0;
		mem_we_o  = 1'b0;
		mem_re_o  = 1'b0;
		wb_sel_o  = rv_core_pkg::WB_ALU;
		imm_o     = imm_i_type;
		op_a_o    = rs1_data_i;
		op_b_o    = imm_i_type;
		case (opcode)
			rv_core_pkg::OPC_LUI: begin
				alu_op_o = rv_core_pkg::ALU_PASS_B;
				imm_o    = imm_u_type;
				op_a_o   = '0;
				op_b_o   = imm_u_type;
				reg_we_o = 1'b1;
			end
			rv_core_pkg::OPC_AUIPC: begin
				imm_o    = imm_u_type;
				op_a_o   = pc_i;
				op_b_o   = imm_u_type;
				reg_we_o = 1'b1;
			end
			rv_core_pkg::OPC_JAL: begin
				is_jal_o = 1'b1;
				imm_o    = imm_j_type;
				op_a_o   = pc_i;
				op_b_o   = imm_j_type;
				reg_we_o = 1'b1;
				wb_sel_o = rv_core_pkg::WB_LINK;
			end
			rv_core_pkg::OPC_JALR: begin
				is_jalr_o = 1'b1;
				reg_we_o  = 1'b1;
				wb_sel_o  = rv_core_pkg::WB_LINK;
			end
			rv_core_pkg::OPC_BRANCH: begin
				br_op_o = br_f;
				imm_o   = imm_b_type;
				op_b_o  = rs2_data_i;
			end
			rv_core_pkg::OPC_LOAD: begin
				mem_re_o = 1'b1;
				reg_we_o = 1'b1;
				wb_sel_o = rv_core_pkg::WB_MEM;
			end
			rv_core_pkg::OPC_STORE: begin
				imm_o    = imm_s_type;
				op_b_o   = imm_s_type;
				mem_we_o = 1'b1;
			end
			rv_core_pkg::OPC_OP_IMM: begin
				alu_op_o = alu_f;
				reg_we_o = 1'b1;
			end
			rv_core_pkg::OPC_OP: begin
				alu_op_o = alu_f;
				op_b_o   = rs2_data_i;
				reg_we_o = 1'b1;
			end
			default: begin
			end
		endcase
	end

endmodule

/* rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile (
	input  logic        clk,
	input  logic        rst_i,
	input  logic [4:0]  rs1_addr_i,
	input  logic [4:0]  rs2_addr_i,
	input  logic        we_i,
	input  logic [4:0]  waddr_i,
	input  logic [31:0] wdata_i,
	output logic [31:0] rs1_data_o,
	output logic [31:0] rs2_data_o
);

	// x0 has no storage
	logic [31:0] regs [31:1];

	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i && waddr_i != 5'd0) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	assign rs1_data_o = (rs1_addr_i == 5'd0) ? 32'd0 : regs[rs1_addr_i];
	assign rs2_data_o = (rs2_addr_i == 5'd0) ? 32'd0 : regs[rs2_addr_i];

endmodule

/* rv_execute.sv */
`timescale 1ns/1ps

module rv_execute (
	input  logic [31:0]          pc_i,
	input  rv_core_pkg::alu_op_e alu_op_i,
	input  rv_core_pkg::br_op_e  br_op_i,
	input  logic                 is_jal_i,
	input  logic                 is_jalr_i,
	input  logic [31:0]          op_a_i,
	input  logic [31:0]          op_b_i,
	input  logic [31:0]          imm_i,
	input  logic [31:0]          rs1_data_i,
	input  logic [31:0]          rs2_data_i,
	output logic [31:0]          alu_res_o,
	output logic                 jump_en_o,
	output logic [31:0]          jump_addr_o
);

	logic [4:0]  shamt;
	logic        cmp_eq;
	logic        cmp_lt;
	logic        cmp_ltu;
	logic        br_taken;
	logic [31:0] jalr_sum;

	assign shamt = op_b_i[4:0];

	// ********************************************************
	// ALU
	// ********************************************************

	always_comb begin
		case (alu_op_i)
			rv_core_pkg::ALU_ADD:    alu_res_o = op_a_i + op_b_i;
			rv_core_pkg::ALU_SUB:    alu_res_o = op_a_i - op_b_i;
			rv_core_pkg::ALU_SLL:    alu_res_o = op_a_i << shamt;
			rv_core_pkg::ALU_SLT:    alu_res_o = {31'd0, $signed(op_a_i) < $signed(op_b_i)};
			rv_core_pkg::ALU_SLTU:   alu_res_o = {31'd0, op_a_i < op_b_i};
			rv_core_pkg::ALU_XOR:    alu_res_o = op_a_i ^ op_b_i;
			rv_core_pkg::ALU_SRL:    alu_res_o = op_a_i >> shamt;
			rv_core_pkg::ALU_SRA:    alu_res_o = $unsigned($signed(op_a_i) >>> shamt);
			rv_core_pkg::ALU_OR:     alu_res_o = op_a_i | op_b_i;
			rv_core_pkg::ALU_AND:    alu_res_o = op_a_i & op_b_i;
			rv_core_pkg::ALU_PASS_B: alu_res_o = op_b_i;
			default:                 alu_res_o = '0;
		endcase
	end

	// ********************************************************
	// Branch comparator and jump target
	// ********************************************************

	assign cmp_eq  = (rs1_data_i == rs2_data_i);
	assign cmp_lt  = ($signed(rs1_data_i) < $signed(rs2_data_i));
	assign cmp_ltu = (rs1_data_i < rs2_data_i);

	always_comb begin
		case (br_op_i)
			rv_core_pkg::BR_EQ:  br_taken = cmp_eq;
			rv_core_pkg::BR_NE:  br_taken = !cmp_eq;
			rv_core_pkg::BR_LT:  br_taken = cmp_lt;
			rv_core_pkg::BR_GE:  br_taken = !cmp_lt;
			rv_core_pkg::BR_LTU: br_taken = cmp_ltu;
			rv_core_pkg::BR_GEU: br_taken = !cmp_ltu;
			default:             br_taken = 1'b0;
		endcase
	end

	assign jalr_sum    = rs1_data_i + imm_i;
	assign jump_addr_o = is_jalr_i ? {jalr_sum[31:1], 1'b0} : pc_i + imm_i;
	assign jump_en_o   = is_jal_i | is_jalr_i | br_taken;

endmodule

/* rv_writeback.sv */
`timescale 1ns/1ps

module rv_writeback (
	input  logic                   clk,
	input  logic                   rst_i,
	input  logic [31:0]            pc_i,
	input  logic [31:0]            alu_res_i,
	input  logic [31:0]            rs2_data_i,
	input  logic [4:0]             rd_addr_i,
	input  logic                   reg_we_i,
	input  logic                   mem_we_i,
	input  logic                   mem_re_i,
	input  rv_core_pkg::mem_size_e mem_size_i,
	input  logic                   load_unsigned_i,
	input  rv_core_pkg::wb_sel_e   wb_sel_i,
	output logic                   rd_we_o,
	output logic [4:0]             rd_waddr_o,
	output logic [31:0]            rd_wdata_o
);

	logic [31:0] dmem [rv_core_pkg::DMEM_DEPTH];

	logic [5:0]  word_idx;
	logic [1:0]  byte_off;
	logic [3:0]  lane_en;
	logic [31:0] st_data;
	logic [31:0] ld_word;
	logic [7:0]  ld_byte;
	logic [15:0] ld_half;
	logic [31:0] ld_data;

	assign word_idx = alu_res_i[7:2];
	assign byte_off = alu_res_i[1:0];

	// Store data is replicated so every lane sees its own copy
	always_comb begin
		case (mem_size_i)
			rv_core_pkg::MEM_BYTE: begin
				lane_en = 4'b0001 << byte_off;
				st_data = {4{rs2_data_i[7:0]}};
			end
			rv_core_pkg::MEM_HALF: begin
				lane_en = byte_off[1] ? 4'b1100 : 4'b0011;
				st_data = {2{rs2_data_i[15:0]}};
			end
			default: begin
				lane_en = 4'b1111;
				st_data = rs2_data_i;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_i && mem_we_i) begin
			for (int i = 0; i < 4; i++) begin
				if (lane_en[i]) dmem[word_idx][8*i +: 8] <= st_data[8*i +: 8];
			end
		end
	end

	// Load lane extraction and extension
	assign ld_word = dmem[word_idx];
	assign ld_byte = ld_word[{byte_off, 3'b000} +: 8];
	assign ld_half = ld_word[{byte_off[1], 4'b0000} +: 16];

	always_comb begin
		case (mem_size_i)
			rv_core_pkg::MEM_BYTE: ld_data = {{24{ld_byte[7] & !load_unsigned_i}}, ld_byte};
			rv_core_pkg::MEM_HALF: ld_data = {{16{ld_half[15] & !load_unsigned_i}}, ld_half};
			default:               ld_data = ld_word;
		endcase
		if (!mem_re_i) ld_data = '0;
	end

	always_comb begin
		case (wb_sel_i)
			rv_core_pkg::WB_MEM:  rd_wdata_o = ld_data;
			rv_core_pkg::WB_LINK: rd_wdata_o = pc_i + 32'd4;
			default:              rd_wdata_o = alu_res_i;
		endcase
	end

	assign rd_waddr_o = rd_addr_i;
	assign rd_we_o    = reg_we_i && (rd_addr_i != 5'd0) && !rst_i; // Nothing retires in reset

endmodule

/* rv_core_top.sv */
`timescale 1ns/1ps

module rv_core_top (
	input  logic                            clk,
	input  logic                            rst_i,
	input  logic                            imem_we_i,
	input  logic [rv_core_pkg::IMEM_AW-1:0] imem_addr_i,
	input  logic [31:0]                     imem_wdata_i,
	output logic                            retire_valid_o,
	output logic [31:0]                     retire_pc_o,
	output logic [31:0]                     retire_instr_o,
	output logic                            rd_we_o,
	output logic [4:0]                      rd_addr_o,
	output logic [31:0]                     rd_data_o
);

	// ********************************************************
	// Interconnect
	// ********************************************************

	logic [31:0] pc;
	logic [31:0] instr;
	logic [4:0]  rs1_addr;
	logic [4:0]  rs2_addr;
	logic [31:0] gpr_rs1;
	logic [31:0] gpr_rs2;
	logic [31:0] rs1_data;
	logic [31:0] rs2_data;
	logic        is_jal;
	logic        is_jalr;
	logic [31:0] op_a;
	logic [31:0] op_b;
	logic [31:0] imm;
	logic [4:0]  rd_addr;
	logic        reg_we;
	logic        mem_we;
	logic        mem_re;
	logic        load_unsigned;
	logic [31:0] alu_res;
	logic        jump_en;
	logic [31:0] jump_addr;
	logic        rd_we;
	logic [4:0]  rd_waddr;
	logic [31:0] rd_wdata;

	rv_core_pkg::alu_op_e   alu_op;
	rv_core_pkg::br_op_e    br_op;
	rv_core_pkg::mem_size_e mem_size;
	rv_core_pkg::wb_sel_e   wb_sel;

	rv_fetch u_rv_fetch (
		.clk         ( clk       ),
		.rst_i       ( rst_i     ),
		.jump_en_i   ( jump_en   ),
		.jump_addr_i ( jump_addr ),
		.pc_o        ( pc        )
	);

	rv_imem u_rv_imem (
		.clk     ( clk          ),
		.rst_i   ( rst_i        ),
		.we_i    ( imem_we_i    ),
		.waddr_i ( imem_addr_i  ),
		.wdata_i ( imem_wdata_i ),
		.pc_i    ( pc           ),
		.instr_o ( instr        )
	);

	rv_decode u_rv_decode (
		.pc_i            ( pc            ),
		.instr_i         ( instr         ),
		.rs1_data_i      ( gpr_rs1       ),
		.rs2_data_i      ( gpr_rs2       ),
		.rs1_addr_o      ( rs1_addr      ),
		.rs2_addr_o      ( rs2_addr      ),
		.alu_op_o        ( alu_op        ),
		.br_op_o         ( br_op         ),
		.is_jal_o        ( is_jal        ),
		.is_jalr_o       ( is_jalr       ),
		.op_a_o          ( op_a          ),
		.op_b_o          ( op_b          ),
		.imm_o           ( imm           ),
		.rs1_data_o      ( rs1_data      ),
		.rs2_data_o      ( rs2_data      ),
		.rd_addr_o       ( rd_addr       ),
		.reg_we_o        ( reg_we        ),
		.mem_we_o        ( mem_we        ),
		.mem_re_o        ( mem_re        ),
		.mem_size_o      ( mem_size      ),
		.load_unsigned_o ( load_unsigned ),
		.wb_sel_o        ( wb_sel        )
	);

	rv_regfile u_rv_regfile (
		.clk        ( clk      ),
		.rst_i      ( rst_i    ),
		.rs1_addr_i ( rs1_addr ),
		.rs2_addr_i ( rs2_addr ),
		.we_i       ( rd_we    ),
		.waddr_i    ( rd_waddr ),
		.wdata_i    ( rd_wdata ),
		.rs1_data_o ( gpr_rs1  ),
		.rs2_data_o ( gpr_rs2  )
	);

	rv_execute u_rv_execute (
		.pc_i        ( pc        ),
		.alu_op_i    ( alu_op    ),
		.br_op_i     ( br_op     ),
		.is_jal_i    ( is_jal    ),
		.is_jalr_i   ( is_jalr   ),
		.op_a_i      ( op_a      ),
		.op_b_i      ( op_b      ),
		.imm_i       ( imm       ),
		.rs1_data_i  ( rs1_data  ),
		.rs2_data_i  ( rs2_data  ),
		.alu_res_o   ( alu_res   ),
		.jump_en_o   ( jump_en   ),
		.jump_addr_o ( jump_addr )
	);

	rv_writeback u_rv_writeback (
		.clk             ( clk           ),
		.rst_i           ( rst_i         ),
		.pc_i            ( pc            ),
		.alu_res_i       ( alu_res       ),
		.rs2_data_i      ( rs2_data      ),
		.rd_addr_i       ( rd_addr       ),
		.reg_we_i        ( reg_we        ),
		.mem_we_i        ( mem_we        ),
		.mem_re_i        ( mem_re        ),
		.mem_size_i      ( mem_size      ),
		.load_unsigned_i ( load_unsigned ),
		.wb_sel_i        ( wb_sel        ),
		.rd_we_o         ( rd_we         ),
		.rd_waddr_o      ( rd_waddr      ),
		.rd_wdata_o      ( rd_wdata      )
	);

	// Trace port, one retire per cycle outside reset
	assign retire_valid_o = !rst_i;
	assign retire_pc_o    = pc;
	assign retire_instr_o = instr;
	assign rd_we_o        = rd_we;
	assign rd_addr_o      = rd_waddr;
	assign rd_data_o      = rd_wdata;

endmodule

/* rv_core_sva.sv */
`timescale 1ns/1ps

module rv_core_sva (
	input logic        clk,
	input logic        rst_i,
	input logic        retire_valid_o,
	input logic [31:0] retire_pc_o,
	input logic [31:0] retire_instr_o,
	input logic        rd_we_o,
	input logic [4:0]  rd_addr_o,
	input logic [31:0] rd_data_o
);

	// Nothing retires while the core is held in reset
	reset_quiet: assert property (@(posedge clk) rst_i |-> !retire_valid_o && !rd_we_o)
		else $error("Trace port active during reset");

	no_x0_write: assert property (@(posedge clk) rd_we_o |-> rd_addr_o != 5'd0)
		else $error("Register write to x0 reported");

	pc_aligned: assert property (@(posedge clk) retire_valid_o |-> retire_pc_o[1:0] == 2'b00)
		else $error("Retired PC is not word aligned");

	trace_known: assert property (@(posedge clk)
		retire_valid_o |-> !$isunknown({retire_pc_o, retire_instr_o, rd_we_o, rd_addr_o}))
		else $error("Unknown value on the trace port");

	wdata_known: assert property (@(posedge clk) retire_valid_o && rd_we_o |-> !$isunknown(rd_data_o))
		else $error("Unknown register write data");

endmodule

bind rv_core_top rv_core_sva rv_core_sva_i (.*);

/* tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core;

	localparam int RESET_CYCLES = 4;
	localparam int LOOP_ITERS   = 16;
	// Program load, reset tail, one pass over the program and the final loop
	localparam int TIMEOUT_CYCLES = rv_core_pkg::IMEM_DEPTH * 2 + RESET_CYCLES + LOOP_ITERS + 32;

	logic                            clk;
	logic                            rst_i;
	logic                            imem_we_i;
	logic [rv_core_pkg::IMEM_AW-1:0] imem_addr_i;
	logic [31:0]                     imem_wdata_i;
	logic                            retire_valid_o;
	logic [31:0]                     retire_pc_o;
	logic [31:0]                     retire_instr_o;
	logic                            rd_we_o;
	logic [4:0]                      rd_addr_o;
	logic [31:0]                     rd_data_o;

	logic [31:0] prog [$];
	logic [31:0] m_imem [rv_core_pkg::IMEM_DEPTH];
	logic [31:0] m_regs [32];
	logic [7:0]  m_mem [256];
	logic [31:0] m_pc;
	logic        exp_we;
	logic [4:0]  exp_rd;
	logic [31:0] exp_data;
	logic [15:0] lfsr_q;
	int          cycle_cnt = 0;

	rv_core_top rv_core_top_i (
		.clk            ( clk            ),
		.rst_i          ( rst_i          ),
		.imem_we_i      ( imem_we_i      ),
		.imem_addr_i    ( imem_addr_i    ),
		.imem_wdata_i   ( imem_wdata_i   ),
		.retire_valid_o ( retire_valid_o ),
		.retire_pc_o    ( retire_pc_o    ),
		.retire_instr_o ( retire_instr_o ),
		.rd_we_o        ( rd_we_o        ),
		.rd_addr_o      ( rd_addr_o      ),
		.rd_data_o      ( rd_data_o      )
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			$display("Timeout: the core did not reach the end of the program in %0d cycles",
				TIMEOUT_CYCLES);
			$display("Test failed");
			$fatal(1);
		end
	end

	// ********************************************************
	// Random source and instruction encoders
	// ********************************************************

	function automatic logic [31:0] lfsr_take(input int n);
		logic [31:0] v;
		logic        lsb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lsb    = lfsr_q[0];
			lfsr_q = lfsr_q >> 1;
			if (lsb) lfsr_q = lfsr_q ^ 16'hB400; // Taps 16, 14, 13, 11
			v = {v[30:0], lsb};
		end
		return v;
	endfunction

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2);
		return {f7, rs2, rs1, f3, rd, rv_core_pkg::OPC_OP};
	endfunction

	function automatic logic [31:0] enc_i(input logic [6:0] opc, input logic [2:0] f3,
		input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] enc_s(input logic [2:0] f3, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [11:0] imm);
		return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_core_pkg::OPC_STORE};
	endfunction

	function automatic logic [31:0] enc_b(input logic [2:0] f3, input logic [4:0] rs1,
		input logic [4:0] rs2, input logic [12:0] imm);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_core_pkg::OPC_BRANCH};
	endfunction

	function automatic logic [31:0] enc_u(input logic [6:0] opc, input logic [4:0] rd,
		input logic [19:0] imm);
		return {imm, rd, opc};
	endfunction

	function automatic logic [31:0] enc_j(input logic [4:0] rd, input logic [20:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_core_pkg::OPC_JAL};
	endfunction

	// Each branch jumps over one ADDI, so taken and not-taken give different traces
	task automatic add_branch(input logic [2:0] f3, input logic [4:0] rs1, input logic [4:0] rs2);
		prog.push_back(enc_b(f3, rs1, rs2, 13'd8));
		prog.push_back(enc_i(rv_core_pkg::OPC_OP_IMM, 3'd0, 5'd23, 5'd0, 12'd1));
	endtask

	task automatic build_program();
		logic [4:0] sh;
		prog.push_back(enc_u(rv_core_pkg::OPC_LUI, 5'd1, 20'(lfsr_take(20))));
		prog.push_back(enc_i(rv_core_pkg::OPC_OP_IMM, 3'd0, 5'd1, 5'd1, 12'(lfsr_take(12))));
		prog.push_back(enc_u(rv_core_pkg::OPC_LUI, 5'd2, 20'(lfsr_take(20))));
		prog.push_back(enc_i(rv_core_pkg::OPC_OP_IMM, 3'd0, 5'd2, 5'd2, 12'(lfsr_take(12))));
		prog.push_back(enc_r(7'h00, 3'd0, 5'd3, 5'd1, 5'd2));  // ADD
		prog.push_back(enc_r(7'h20, 3'd0, 5'd4, 5'd1, 5'd2));  // SUB
		prog.push_back(enc_r(7'h00, 3'd1, 5'd5, 5'd1, 5'd2));
		prog.push_back(enc_r(7'h00, 3'd2, 5'd6, 5'd1, 5'd2));
		prog.push_back(enc_r(7'h00, 3'd3, 5'd7, 5'd1, 5'd2));
		prog.push_back(enc_r(7'h00, 3'd4, 5'd8, 5'd1, 5'd2));
		prog.push_back(enc_r(7'h00, 3'd5, 5'd9, 5'd1, 5'd2));
		prog.push_back(enc_r(7'h20, 3'd5, 5'd10, 5'd1, 5'd2)); // SRA
		prog.push_back(enc_r(7'h00, 3'd6, 5'd11, 5'd1, 5'd2));
		prog.push_back(enc_r(7'h00, 3'd7, 5'd12, 5'd1, 5'd2));
		prog.push_back(enc_i(rv_core_pkg::OPC_OP_IMM, 3'd2, 5'd13, 5'd1, 12'(lfsr_take(12))));
		prog.push_back(enc_i(rv_core_pkg::OPC_OP_IMM, 3'd3, 5'd14, 5'd1, 12'(lfsr_take(12))));
		prog.push_back(enc_i(rv_core_pkg::OPC_OP_IMM, 3'd4, 5'd15, 5'd1, 12'(lfsr_take(12))));
		prog.push_back(enc_i(rv_core_pkg::OPC_OP_IMM, 3'd6, 5'd16, 5'd1, 12'(lfsr_take(12))));
		prog.push_back(enc_i(rv_core_pkg::OPC_OP_IMM, 3'd7, 5'd17, 5'd1, 12'(lfsr_take(12))));
		sh = 5'(lfsr_take(5));
		prog.push_back(enc_i(rv_core_pkg::OPC_OP_IMM, 3'd1, 5'd18, 5'd1, {7'h00, sh}));
		prog.push_back(enc_i(rv_core_pkg::OPC_OP_IMM, 3'd5, 5'd19, 5'd1, {7'h00, sh}));
		prog.push_back(enc_i(rv_core_pkg::OPC_OP_IMM, 3'd5, 5'd20, 5'd1, {7'h20, sh}));
		prog.push_back(enc_u(rv_core_pkg::OPC_AUIPC, 5'd21, 20'(lfsr_take(20))));
		prog.push_back(enc_i(rv_core_pkg::OPC_OP_IMM, 3'd0, 5'd0, 5'd1, 12'd5)); // Write to x0
		prog.push_back(enc_r(7'h00, 3'd0, 5'd22, 5'd0, 5'd1));
		prog.push_back(enc_i(rv_core_pkg::OPC_OP_IMM, 3'd0, 5'd24, 5'd0, 12'hFFF));
		// ********************************************************
		// Branches, x24 = -1 and x0 = 0
		// ********************************************************
		add_branch(3'd0, 5'd1, 5'd1);
		add_branch(3'd0, 5'd24, 5'd0);
		add_branch(3'd1, 5'd24, 5'd0);
		add_branch(3'd1, 5'd1, 5'd1);
		add_branch(3'd4, 5'd24, 5'd0);
		add_branch(3'd4, 5'd0, 5'd24);
		add_branch(3'd5, 5'd0, 5'd24);
		add_branch(3'd5, 5'd24, 5'd0);
		add_branch(3'd6, 5'd0, 5'd24);
		add_branch(3'd6, 5'd24, 5'd0);
		add_branch(3'd7, 5'd24, 5'd0);
		add_branch(3'd7, 5'd0, 5'd24);
		// Stores then loads of each size
		prog.push_back(enc_i(rv_core_pkg::OPC_OP_IMM, 3'd0, 5'd26, 5'd0, 12'h040));
		prog.push_back(enc_s(3'd2, 5'd1, 5'd26, 12'd0));
		prog.push_back(enc_s(3'd1, 5'd2, 5'd26, 12'd4));
		prog.push_back(enc_s(3'd0, 5'd2, 5'd26, 12'd6));
		prog.push_back(enc_i(rv_core_pkg::OPC_LOAD, 3'd2, 5'd27, 5'd26, 12'd0));
		prog.push_back(enc_i(rv_core_pkg::OPC_LOAD, 3'd1, 5'd28, 5'd26, 12'd2));
		prog.push_back(enc_i(rv_core_pkg::OPC_LOAD, 3'd5, 5'd29, 5'd26, 12'd4));
		prog.push_back(enc_i(rv_core_pkg::OPC_LOAD, 3'd0, 5'd30, 5'd26, 12'd6));
		prog.push_back(enc_i(rv_core_pkg::OPC_LOAD, 3'd4, 5'd31, 5'd26, 12'd6));
		// Jumps, the JALR takes the JAL link as base and its odd offset needs bit 0 cleared
		prog.push_back(enc_j(5'd5, 21'd8));
		prog.push_back(enc_i(rv_core_pkg::OPC_OP_IMM, 3'd0, 5'd23, 5'd0, 12'd2));
		prog.push_back(enc_i(rv_core_pkg::OPC_JALR, 3'd0, 5'd7, 5'd5, 12'd13));
		prog.push_back(enc_i(rv_core_pkg::OPC_OP_IMM, 3'd0, 5'd23, 5'd0, 12'd3));
		prog.push_back(enc_j(5'd0, 21'd0)); // Parks the core
	endtask

	// ********************************************************
	// ISA reference model
	// ********************************************************

	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
		input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0:    return alt ? a - b : a + b;
			3'd1:    return a << b[4:0];
			3'd2:    return {31'd0, $signed(a) < $signed(b)};
			3'd3:    return {31'd0, a < b};
			3'd4:    return a ^ b;
			3'd5:    return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6:    return a | b;
			default: return a & b;
		endcase
	endfunction

	task automatic step_model(input logic [31:0] ins);
		logic [2:0]  f3;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm_i;
		logic [31:0] imm_s;
		logic [31:0] imm_b;
		logic [7:0]  addr;
		logic [31:0] res;
		logic [31:0] npc;
		logic        we;
		logic        taken;
		f3    = ins[14:12];
		a     = m_regs[ins[19:15]];
		b     = m_regs[ins[24:20]];
		imm_i = {{20{ins[31]}}, ins[31:20]};
		imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
		npc   = m_pc + 4;
		res   = '0;
		we    = 1'b0;
		case (ins[6:0])
			rv_core_pkg::OPC_LUI: begin
				res = {ins[31:12], 12'd0};
				we  = 1'b1;
			end
			rv_core_pkg::OPC_AUIPC: begin
				res = m_pc + {ins[31:12], 12'd0};
				we  = 1'b1;
			end
			rv_core_pkg::OPC_JAL: begin
				res = m_pc + 4;
				we  = 1'b1;
				npc = m_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
			end
			rv_core_pkg::OPC_JALR: begin
				res = m_pc + 4;
				we  = 1'b1;
				npc = (a + imm_i) & ~32'd1;
			end
			rv_core_pkg::OPC_BRANCH: begin
				case (f3)
					3'd0:    taken = a == b;
					3'd1:    taken = a != b;
					3'd4:    taken = $signed(a) < $signed(b);
					3'd5:    taken = $signed(a) >= $signed(b);
					3'd6:    taken = a < b;
					default: taken = a >= b;
				endcase
				if (taken) npc = m_pc + imm_b;
			end
			rv_core_pkg::OPC_LOAD: begin
				addr = a[7:0] + imm_i[7:0];
				we   = 1'b1;
				case (f3)
					3'd0: res = {{24{m_mem[addr][7]}}, m_mem[addr]};
					3'd1: res = {{16{m_mem[addr + 1][7]}}, m_mem[addr + 1], m_mem[addr]};
					3'd4: res = {24'd0, m_mem[addr]};
					3'd5: res = {16'd0, m_mem[addr + 1], m_mem[addr]};
					default: res = {m_mem[addr + 3], m_mem[addr + 2], m_mem[addr + 1], m_mem[addr]};
				endcase
			end
			rv_core_pkg::OPC_STORE: begin
				addr = a[7:0] + imm_s[7:0];
				for (int i = 0; i < (1 << f3[1:0]); i++) begin
					m_mem[addr + i] = b[8*i +: 8];
				end
			end
			rv_core_pkg::OPC_OP_IMM: begin
				res = alu_ref(f3, f3 == 3'd5 && ins[30], a, imm_i);
				we  = 1'b1;
			end
			rv_core_pkg::OPC_OP: begin
				res = alu_ref(f3, ins[30], a, b);
				we  = 1'b1;
			end
			default: begin
			end
		endcase
		exp_we   = we && ins[11:7] != 5'd0;
		exp_rd   = ins[11:7];
		exp_data = res;
		if (exp_we) m_regs[ins[11:7]] = res;
		m_pc = npc;
	endtask

	task automatic compare_signal(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	// ********************************************************
	// Main sequence
	// ********************************************************

	initial begin
		logic [31:0] cur_pc;
		logic [31:0] cur_ins;
		logic [31:0] end_pc;
		int          loops;
		rst_i        = 1'b1;
		imem_we_i    = 1'b0;
		imem_addr_i  = '0;
		imem_wdata_i = '0;
		lfsr_q       = 16'd6;
		m_pc         = rv_core_pkg::RESET_PC;
		for (int i = 0; i < 32; i++) m_regs[i] = '0;
		for (int i = 0; i < 256; i++) m_mem[i] = '0;
		build_program();
		if (prog.size() > rv_core_pkg::IMEM_DEPTH) begin
			$display("The test program does not fit into the instruction memory");
			$display("Test failed");
			$fatal(1);
		end
		for (int i = 0; i < rv_core_pkg::IMEM_DEPTH; i++) begin
			m_imem[i] = (i < prog.size()) ? prog[i] : 32'd0; // Zero words decode as no-ops
			@(negedge clk);
			imem_we_i    = 1'b1;
			imem_addr_i  = i[rv_core_pkg::IMEM_AW-1:0];
			imem_wdata_i = m_imem[i];
		end
		@(negedge clk);
		imem_we_i = 1'b0;
		repeat (RESET_CYCLES - 1) @(negedge clk);
		rst_i  = 1'b0;
		end_pc = rv_core_pkg::RESET_PC + (prog.size() - 1) * 4;
		loops  = 0;
		while (loops < LOOP_ITERS) begin
			#1;
			cur_pc  = m_pc;
			cur_ins = m_imem[cur_pc[rv_core_pkg::IMEM_AW+1:2]];
			step_model(cur_ins);
			compare_signal("retire_valid_o", retire_valid_o, 1'b1);
			compare_signal("retire_pc_o", retire_pc_o, cur_pc);
			compare_signal("retire_instr_o", retire_instr_o, cur_ins);
			compare_signal("rd_we_o", rd_we_o, exp_we);
			if (exp_we) begin
				compare_signal("rd_addr_o", rd_addr_o, exp_rd);
				compare_signal("rd_data_o", rd_data_o, exp_data);
			end
			if (cur_pc == end_pc) loops++;
			@(negedge clk);
		end
		$display("Test completed successfully");
		$finish;
	end

endmodule

/* build.f */
rv_core_pkg.sv
rv_fetch.sv
rv_imem.sv
rv_decode.sv
rv_regfile.sv
rv_execute.sv
rv_writeback.sv
rv_core_top.sv
rv_core_sva.sv
tb_rv_core.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - rv_core_pkg.sv
  - rv_fetch.sv
  - rv_imem.sv
  - rv_decode.sv
  - rv_regfile.sv
  - rv_execute.sv
  - rv_writeback.sv
  - rv_core_top.sv
  - target: test
    files:
      - rv_core_sva.sv
      - tb_rv_core.sv
